// ==== source/sim_sram_pkg.sv ====
// Simulation SRAM shared types.
// Opcodes for the request and response channels, the request tag
// and the route marker used to keep responses in order.

`default_nettype none

package sim_sram_pkg;

  // Request opcodes.
  typedef enum logic [1:0] {
    PutFullData    = 2'd0,
    PutPartialData = 2'd1,
    Get            = 2'd2
  } a_op_e;

  // Response opcodes.
  // Writes are acknowledged without data.
  typedef enum logic [0:0] {
    AccessAck     = 1'b0,
    AccessAckData = 1'b1
  } d_op_e;

  // Request tag carried back on the response.
  parameter int SourceWidth = 4;

  typedef logic [SourceWidth-1:0] source_t;

  // Path taken by a request.
  typedef enum logic [0:0] {
    RouteOut  = 1'b0,
    RouteSram = 1'b1
  } route_e;

endpackage

`default_nettype wire

// ==== source/sram_1p.sv ====
// Single-port word memory.
// Byte-masked writes, registered read data one cycle after the request.

`timescale 1ns/1ps
`default_nettype none

module sram_1p #(
  parameter int DataWidth = 32,
  parameter int Depth     = 8,
  localparam int Bytes      = DataWidth / 8,
  localparam int IndexWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                  clk_i,
  input  logic                  req_i,
  input  logic                  write_i,
  input  logic [IndexWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]  wdata_i,
  input  logic [Bytes-1:0]      wmask_i,
  output logic [DataWidth-1:0]  rdata_o
);

  logic [DataWidth-1:0] mem_q [Depth];

  // Only the bytes with their mask bit set are written.
  // A read leaves rdata_o stable until the next read.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        for (int b = 0; b < Bytes; b++) begin
          if (wmask_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/sram_adapter.sv ====
// SRAM bus adapter.
// Converts in-window bus requests into SRAM accesses and keeps
// their responses in a two-entry queue.

`timescale 1ns/1ps
`default_nettype none

module sram_adapter #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32,
  parameter int Depth     = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [AddrWidth-1:0]  start_addr_i,

  input  logic                  a_valid_i,
  output logic                  a_ready_o,
  input  sim_sram_pkg::a_op_e   a_opcode_i,
  input  logic [AddrWidth-1:0]  a_address_i,
  input  logic [DataWidth/8-1:0] a_mask_i,
  input  logic [DataWidth-1:0]  a_data_i,
  input  sim_sram_pkg::source_t a_source_i,

  output logic                  d_valid_o,
  input  logic                  d_ready_i,
  output sim_sram_pkg::d_op_e   d_opcode_o,
  output logic [DataWidth-1:0]  d_data_o,
  output sim_sram_pkg::source_t d_source_o,
  output logic                  d_error_o
);
  import sim_sram_pkg::*;

  localparam int Bytes      = DataWidth / 8;
  localparam int ByteShift  = (Bytes > 1) ? $clog2(Bytes) : 0;
  localparam int IndexWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [AddrWidth-1:0]  offset;
  logic [IndexWidth-1:0] index;
  logic [Bytes-1:0]      wmask;
  logic [DataWidth-1:0]  rdata;
  logic                  write;
  logic                  push;
  logic                  pop;

  // Two-entry response queue.
  logic [1:0]            count_q;
  logic                  wptr_q;
  logic                  rptr_q;
  d_op_e                 op_q   [2];
  source_t               src_q  [2];
  logic [DataWidth-1:0]  data_q [2];

  // Read issued on the previous edge, and the slot waiting for its data.
  logic                  rd_pend_q;
  logic                  rd_slot_q;

  // Word index relative to the window start.
  assign offset = a_address_i - start_addr_i;
  assign index  = offset[ByteShift +: IndexWidth];

  assign write = (a_opcode_i != Get);
  assign wmask = (a_opcode_i == PutFullData) ? {Bytes{1'b1}} : a_mask_i;

  assign a_ready_o = (count_q != 2'd2);
  assign push      = a_valid_i & a_ready_o;
  assign d_valid_o = (count_q != 2'd0);
  assign pop       = d_valid_o & d_ready_i;

  sram_1p #(
    .DataWidth(DataWidth),
    .Depth    (Depth)
  ) sram_1p_inst (
    .clk_i,
    .req_i  (push),
    .write_i(write),
    .addr_i (index),
    .wdata_i(a_data_i),
    .wmask_i(wmask),
    .rdata_o(rdata)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q   <= 2'd0;
      wptr_q    <= 1'b0;
      rptr_q    <= 1'b0;
      rd_pend_q <= 1'b0;
      rd_slot_q <= 1'b0;
    end else begin
      count_q   <= count_q + {1'b0, push} - {1'b0, pop};
      rd_pend_q <= push & ~write;
      if (push) begin
        wptr_q    <= ~wptr_q;
        rd_slot_q <= wptr_q;
      end
      if (pop) begin
        rptr_q <= ~rptr_q;
      end
    end
  end

  // Read data lands in its slot one cycle after the access.
  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wptr_q]  <= write ? AccessAck : AccessAckData;
      src_q[wptr_q] <= a_source_i;
      if (write) begin
        data_q[wptr_q] <= '0;
      end
    end
    if (rd_pend_q) begin
      data_q[rd_slot_q] <= rdata;
    end
  end

  assign d_opcode_o = op_q[rptr_q];
  assign d_source_o = src_q[rptr_q];

  // Bypass the memory output while the head read is still being captured.
  assign d_data_o = (rd_pend_q && (rd_slot_q == rptr_q)) ? rdata : data_q[rptr_q];

  assign d_error_o = 1'b0;

endmodule

`default_nettype wire

// ==== source/bus_steer.sv ====
// Request steering.
// Compares each request against the SRAM window and hands it to the
// SRAM path or the outbound path, recording the route on acceptance.

`timescale 1ns/1ps
`default_nettype none

module bus_steer #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32,
  parameter int Depth     = 8
) (
  input  logic [AddrWidth-1:0]   start_addr_i,

  input  logic                   in_a_valid_i,
  output logic                   in_a_ready_o,
  input  sim_sram_pkg::a_op_e    in_a_opcode_i,
  input  logic [AddrWidth-1:0]   in_a_address_i,
  input  logic [DataWidth/8-1:0] in_a_mask_i,
  input  logic [DataWidth-1:0]   in_a_data_i,
  input  sim_sram_pkg::source_t  in_a_source_i,

  output logic                   sram_a_valid_o,
  input  logic                   sram_a_ready_i,
  output sim_sram_pkg::a_op_e    sram_a_opcode_o,
  output logic [AddrWidth-1:0]   sram_a_address_o,
  output logic [DataWidth/8-1:0] sram_a_mask_o,
  output logic [DataWidth-1:0]   sram_a_data_o,
  output sim_sram_pkg::source_t  sram_a_source_o,

  output logic                   out_a_valid_o,
  input  logic                   out_a_ready_i,
  output sim_sram_pkg::a_op_e    out_a_opcode_o,
  output logic [AddrWidth-1:0]   out_a_address_o,
  output logic [DataWidth/8-1:0] out_a_mask_o,
  output logic [DataWidth-1:0]   out_a_data_o,
  output sim_sram_pkg::source_t  out_a_source_o,

  input  logic                   route_ready_i,
  output logic                   route_push_o,
  output sim_sram_pkg::route_e   route_o
);
  import sim_sram_pkg::*;

  localparam int Bytes       = DataWidth / 8;
  localparam int WindowBytes = Depth * Bytes;

  // One extra bit so a window at the top of the address space does not wrap.
  logic [AddrWidth:0] limit;
  logic               in_window;

  assign limit     = {1'b0, start_addr_i} + (AddrWidth + 1)'(WindowBytes);
  assign in_window = (in_a_address_i >= start_addr_i) && ({1'b0, in_a_address_i} < limit);

  // Valid is held back while the route queue is full, so neither path
  // can take a request that the merger has not recorded.
  assign sram_a_valid_o = in_a_valid_i & route_ready_i & in_window;
  assign out_a_valid_o  = in_a_valid_i & route_ready_i & ~in_window;

  assign in_a_ready_o = route_ready_i & (in_window ? sram_a_ready_i : out_a_ready_i);

  // Payload goes to both paths; only the selected one sees valid.
  assign sram_a_opcode_o  = in_a_opcode_i;
  assign sram_a_address_o = in_a_address_i;
  assign sram_a_mask_o    = in_a_mask_i;
  assign sram_a_data_o    = in_a_data_i;
  assign sram_a_source_o  = in_a_source_i;

  assign out_a_opcode_o  = in_a_opcode_i;
  assign out_a_address_o = in_a_address_i;
  assign out_a_mask_o    = in_a_mask_i;
  assign out_a_data_o    = in_a_data_i;
  assign out_a_source_o  = in_a_source_i;

  assign route_push_o = in_a_valid_i & in_a_ready_o;
  assign route_o      = in_window ? RouteSram : RouteOut;

endmodule

`default_nettype wire

// ==== source/resp_merge.sv ====
// Response merger.
// Keeps the route of every accepted request and connects the matching
// path's response channel to the inbound one, in request order.

`timescale 1ns/1ps
`default_nettype none

module resp_merge #(
  parameter int DataWidth  = 32,
  parameter int RouteDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  route_push_i,
  input  sim_sram_pkg::route_e  route_i,
  output logic                  route_ready_o,

  input  logic                  sram_d_valid_i,
  output logic                  sram_d_ready_o,
  input  sim_sram_pkg::d_op_e   sram_d_opcode_i,
  input  logic [DataWidth-1:0]  sram_d_data_i,
  input  sim_sram_pkg::source_t sram_d_source_i,
  input  logic                  sram_d_error_i,

  input  logic                  out_d_valid_i,
  output logic                  out_d_ready_o,
  input  sim_sram_pkg::d_op_e   out_d_opcode_i,
  input  logic [DataWidth-1:0]  out_d_data_i,
  input  sim_sram_pkg::source_t out_d_source_i,
  input  logic                  out_d_error_i,

  output logic                  in_d_valid_o,
  input  logic                  in_d_ready_i,
  output sim_sram_pkg::d_op_e   in_d_opcode_o,
  output logic [DataWidth-1:0]  in_d_data_o,
  output sim_sram_pkg::source_t in_d_source_o,
  output logic                  in_d_error_o
);
  import sim_sram_pkg::*;

  localparam int PtrWidth   = (RouteDepth > 1) ? $clog2(RouteDepth) : 1;
  localparam int CountWidth = $clog2(RouteDepth + 1);

  route_e                queue_q [RouteDepth];
  logic [PtrWidth-1:0]   wptr_q;
  logic [PtrWidth-1:0]   rptr_q;
  logic [CountWidth-1:0] count_q;
  route_e                head;
  logic                  sel_sram;
  logic                  sel_out;
  logic                  pop;

  assign route_ready_o = (count_q != CountWidth'(RouteDepth));

  // With an empty queue neither path is selected.
  assign head     = queue_q[rptr_q];
  assign sel_sram = (count_q != '0) && (head == RouteSram);
  assign sel_out  = (count_q != '0) && (head == RouteOut);

  assign in_d_valid_o   = (sel_sram & sram_d_valid_i) | (sel_out & out_d_valid_i);
  assign sram_d_ready_o = sel_sram & in_d_ready_i;
  assign out_d_ready_o  = sel_out & in_d_ready_i;

  assign in_d_opcode_o = sel_sram ? sram_d_opcode_i : out_d_opcode_i;
  assign in_d_data_o   = sel_sram ? sram_d_data_i : out_d_data_i;
  assign in_d_source_o = sel_sram ? sram_d_source_i : out_d_source_i;
  assign in_d_error_o  = sel_sram ? sram_d_error_i : out_d_error_i;

  assign pop = in_d_valid_o & in_d_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      count_q <= count_q + CountWidth'(route_push_i) - CountWidth'(pop);
      if (route_push_i) begin
        wptr_q <= (wptr_q == PtrWidth'(RouteDepth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrWidth'(RouteDepth - 1)) ? '0 : rptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (route_push_i) begin
      queue_q[wptr_q] <= route_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/sim_sram.sv ====
// Simulation SRAM interceptor.
// Requests inside the runtime window are served by a local SRAM, all
// others pass to the outbound port; responses return in request order.

`timescale 1ns/1ps
`default_nettype none

module sim_sram #(
  parameter int AddrWidth  = 32,
  parameter int DataWidth  = 32,
  parameter int Depth      = 8,
  parameter int RouteDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [AddrWidth-1:0]   start_addr_i,

  input  logic                   in_a_valid_i,
  output logic                   in_a_ready_o,
  input  sim_sram_pkg::a_op_e    in_a_opcode_i,
  input  logic [AddrWidth-1:0]   in_a_address_i,
  input  logic [DataWidth/8-1:0] in_a_mask_i,
  input  logic [DataWidth-1:0]   in_a_data_i,
  input  sim_sram_pkg::source_t  in_a_source_i,

  output logic                   in_d_valid_o,
  input  logic                   in_d_ready_i,
  output sim_sram_pkg::d_op_e    in_d_opcode_o,
  output logic [DataWidth-1:0]   in_d_data_o,
  output sim_sram_pkg::source_t  in_d_source_o,
  output logic                   in_d_error_o,

  output logic                   out_a_valid_o,
  input  logic                   out_a_ready_i,
  output sim_sram_pkg::a_op_e    out_a_opcode_o,
  output logic [AddrWidth-1:0]   out_a_address_o,
  output logic [DataWidth/8-1:0] out_a_mask_o,
  output logic [DataWidth-1:0]   out_a_data_o,
  output sim_sram_pkg::source_t  out_a_source_o,

  input  logic                   out_d_valid_i,
  output logic                   out_d_ready_o,
  input  sim_sram_pkg::d_op_e    out_d_opcode_i,
  input  logic [DataWidth-1:0]   out_d_data_i,
  input  sim_sram_pkg::source_t  out_d_source_i,
  input  logic                   out_d_error_i
);
  import sim_sram_pkg::*;

  // SRAM path request channel.
  logic                   sram_a_valid;
  logic                   sram_a_ready;
  a_op_e                  sram_a_opcode;
  logic [AddrWidth-1:0]   sram_a_address;
  logic [DataWidth/8-1:0] sram_a_mask;
  logic [DataWidth-1:0]   sram_a_data;
  source_t                sram_a_source;

  // SRAM path response channel.
  logic                   sram_d_valid;
  logic                   sram_d_ready;
  d_op_e                  sram_d_opcode;
  logic [DataWidth-1:0]   sram_d_data;
  source_t                sram_d_source;
  logic                   sram_d_error;

  logic                   route_ready;
  logic                   route_push;
  route_e                 route;

  bus_steer #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .Depth    (Depth)
  ) bus_steer_inst (
    .start_addr_i,
    .in_a_valid_i,
    .in_a_ready_o,
    .in_a_opcode_i,
    .in_a_address_i,
    .in_a_mask_i,
    .in_a_data_i,
    .in_a_source_i,
    .sram_a_valid_o  (sram_a_valid),
    .sram_a_ready_i  (sram_a_ready),
    .sram_a_opcode_o (sram_a_opcode),
    .sram_a_address_o(sram_a_address),
    .sram_a_mask_o   (sram_a_mask),
    .sram_a_data_o   (sram_a_data),
    .sram_a_source_o (sram_a_source),
    .out_a_valid_o,
    .out_a_ready_i,
    .out_a_opcode_o,
    .out_a_address_o,
    .out_a_mask_o,
    .out_a_data_o,
    .out_a_source_o,
    .route_ready_i   (route_ready),
    .route_push_o    (route_push),
    .route_o         (route)
  );

  sram_adapter #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .Depth    (Depth)
  ) sram_adapter_inst (
    .clk_i,
    .rst_ni,
    .start_addr_i,
    .a_valid_i  (sram_a_valid),
    .a_ready_o  (sram_a_ready),
    .a_opcode_i (sram_a_opcode),
    .a_address_i(sram_a_address),
    .a_mask_i   (sram_a_mask),
    .a_data_i   (sram_a_data),
    .a_source_i (sram_a_source),
    .d_valid_o  (sram_d_valid),
    .d_ready_i  (sram_d_ready),
    .d_opcode_o (sram_d_opcode),
    .d_data_o   (sram_d_data),
    .d_source_o (sram_d_source),
    .d_error_o  (sram_d_error)
  );

  resp_merge #(
    .DataWidth (DataWidth),
    .RouteDepth(RouteDepth)
  ) resp_merge_inst (
    .clk_i,
    .rst_ni,
    .route_push_i   (route_push),
    .route_i        (route),
    .route_ready_o  (route_ready),
    .sram_d_valid_i (sram_d_valid),
    .sram_d_ready_o (sram_d_ready),
    .sram_d_opcode_i(sram_d_opcode),
    .sram_d_data_i  (sram_d_data),
    .sram_d_source_i(sram_d_source),
    .sram_d_error_i (sram_d_error),
    .out_d_valid_i,
    .out_d_ready_o,
    .out_d_opcode_i,
    .out_d_data_i,
    .out_d_source_i,
    .out_d_error_i,
    .in_d_valid_o,
    .in_d_ready_i,
    .in_d_opcode_o,
    .in_d_data_o,
    .in_d_source_o,
    .in_d_error_o
  );

endmodule

`default_nettype wire

// ==== bench/tb_downstream_model.sv ====
// Outbound device model.
// Accepts one forwarded request at a time and answers it after a
// random delay of 0 to 5 cycles, with data derived from the address.

`timescale 1ns/1ps
`default_nettype none

module tb_downstream_model #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32,
  parameter int Seed      = 32'h0aecae09
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   a_valid_i,
  output logic                   a_ready_o,
  input  sim_sram_pkg::a_op_e    a_opcode_i,
  input  logic [AddrWidth-1:0]   a_address_i,
  input  logic [DataWidth/8-1:0] a_mask_i,
  input  logic [DataWidth-1:0]   a_data_i,
  input  sim_sram_pkg::source_t  a_source_i,
  output logic                   d_valid_o,
  input  logic                   d_ready_i,
  output sim_sram_pkg::d_op_e    d_opcode_o,
  output logic [DataWidth-1:0]   d_data_o,
  output sim_sram_pkg::source_t  d_source_o,
  output logic                   d_error_o
);
  import sim_sram_pkg::*;

  integer               seed;
  int                   delay;
  logic                 busy;
  logic                 a_take = 1'b0;
  logic                 d_take = 1'b0;
  logic [AddrWidth-1:0] take_addr;
  source_t              take_src;

  // Handshakes are judged at the falling edge, where both sides are stable.
  always @(negedge clk_i) begin
    a_take    = a_valid_i && a_ready_o;
    d_take    = d_valid_o && d_ready_i;
    take_addr = a_address_i;
    take_src  = a_source_i;
  end

  initial begin
    seed       = Seed;
    delay      = 0;
    busy       = 1'b0;
    a_ready_o  = 1'b0;
    d_valid_o  = 1'b0;
    d_opcode_o = AccessAckData;
    d_data_o   = '0;
    d_source_o = '0;
    d_error_o  = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (!rst_ni) begin
        busy      = 1'b0;
        d_valid_o = 1'b0;
      end else begin
        if (d_take) begin
          busy      = 1'b0;
          d_valid_o = 1'b0;
        end
        if (a_take) begin
          busy       = 1'b1;
          delay      = {$random(seed)} % 6;
          d_data_o   = take_addr ^ 32'h5a5a5a5a;
          d_source_o = take_src;
          // Address bit 2 marks a failing access.
          d_error_o  = take_addr[2];
        end
        if (busy && !d_valid_o) begin
          if (delay == 0) begin
            d_valid_o = 1'b1;
          end else begin
            delay--;
          end
        end
      end
      a_ready_o = rst_ni && !busy;
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_sim_sram.sv ====
// Testbench for the simulation SRAM interceptor.
// Sends in-window and outbound traffic, keeps a reference memory and a
// queue of expected responses, and checks every response in order.

`timescale 1ns/1ps
`default_nettype none

module tb_sim_sram;
  import sim_sram_pkg::*;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int Depth     = 8;
  localparam int Seed      = 32'h0aecae09;
  localparam int Timeout   = 200;
  localparam logic [AddrWidth-1:0] StartAddr = 32'h0000_1000;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 in_a_valid;
  logic                 in_a_ready;
  a_op_e                in_a_opcode;
  logic [AddrWidth-1:0] in_a_address;
  logic [3:0]           in_a_mask;
  logic [DataWidth-1:0] in_a_data;
  source_t              in_a_source;
  logic                 in_d_valid;
  logic                 in_d_ready;
  d_op_e                in_d_opcode;
  logic [DataWidth-1:0] in_d_data;
  source_t              in_d_source;
  logic                 in_d_error;
  logic                 out_a_valid;
  logic                 out_a_ready;
  a_op_e                out_a_opcode;
  logic [AddrWidth-1:0] out_a_address;
  logic [3:0]           out_a_mask;
  logic [DataWidth-1:0] out_a_data;
  source_t              out_a_source;
  logic                 out_d_valid;
  logic                 out_d_ready;
  d_op_e                out_d_opcode;
  logic [DataWidth-1:0] out_d_data;
  source_t              out_d_source;
  logic                 out_d_error;

  integer               seed;
  integer               ready_seed;
  int                   errors = 0;
  logic                 ready_random = 1'b0;
  source_t              next_src;
  logic                 stalled = 1'b0;
  logic [38:0]          held;

  // Reference memory and the queue of expected responses in request order.
  logic [DataWidth-1:0] ref_mem [Depth];
  d_op_e                exp_op [$];
  logic [DataWidth-1:0] exp_data [$];
  logic                 exp_check_data [$];
  source_t              exp_src [$];
  logic                 exp_err [$];

  always #5 clk = ~clk;

  sim_sram #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .Depth     (Depth),
    .RouteDepth(4)
  ) sim_sram_inst (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .start_addr_i   (StartAddr),
    .in_a_valid_i   (in_a_valid),
    .in_a_ready_o   (in_a_ready),
    .in_a_opcode_i  (in_a_opcode),
    .in_a_address_i (in_a_address),
    .in_a_mask_i    (in_a_mask),
    .in_a_data_i    (in_a_data),
    .in_a_source_i  (in_a_source),
    .in_d_valid_o   (in_d_valid),
    .in_d_ready_i   (in_d_ready),
    .in_d_opcode_o  (in_d_opcode),
    .in_d_data_o    (in_d_data),
    .in_d_source_o  (in_d_source),
    .in_d_error_o   (in_d_error),
    .out_a_valid_o  (out_a_valid),
    .out_a_ready_i  (out_a_ready),
    .out_a_opcode_o (out_a_opcode),
    .out_a_address_o(out_a_address),
    .out_a_mask_o   (out_a_mask),
    .out_a_data_o   (out_a_data),
    .out_a_source_o (out_a_source),
    .out_d_valid_i  (out_d_valid),
    .out_d_ready_o  (out_d_ready),
    .out_d_opcode_i (out_d_opcode),
    .out_d_data_i   (out_d_data),
    .out_d_source_i (out_d_source),
    .out_d_error_i  (out_d_error)
  );

  tb_downstream_model #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .Seed     (Seed)
  ) downstream_inst (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .a_valid_i  (out_a_valid),
    .a_ready_o  (out_a_ready),
    .a_opcode_i (out_a_opcode),
    .a_address_i(out_a_address),
    .a_mask_i   (out_a_mask),
    .a_data_i   (out_a_data),
    .a_source_i (out_a_source),
    .d_valid_o  (out_d_valid),
    .d_ready_i  (out_d_ready),
    .d_opcode_o (out_d_opcode),
    .d_data_o   (out_d_data),
    .d_source_o (out_d_source),
    .d_error_o  (out_d_error)
  );

  // Forwarded requests leave with the fields they arrived with.
  assert property (@(posedge clk) disable iff (!rst_n)
    out_a_valid |-> out_a_address == in_a_address)
    else begin
      errors++;
      $display("Mismatch out_a_address_o: expected %h, got %h", in_a_address, out_a_address);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_a_valid |-> {out_a_opcode, out_a_mask, out_a_data, out_a_source} ==
                    {in_a_opcode, in_a_mask, in_a_data, in_a_source})
    else begin
      errors++;
      $display("Mismatch out_a payload: expected %h, got %h",
               {in_a_opcode, in_a_mask, in_a_data, in_a_source},
               {out_a_opcode, out_a_mask, out_a_data, out_a_source});
    end

  task automatic finish_run();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("%s", what);
    finish_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
      else begin
        errors++;
        $display("Mismatch %s: expected %h, got %h", name, expected, actual);
      end
  endtask

  task automatic expect_response(input d_op_e op, input logic [DataWidth-1:0] data,
                                 input logic check_data, input source_t src,
                                 input logic err);
    exp_op.push_back(op);
    exp_data.push_back(data);
    exp_check_data.push_back(check_data);
    exp_src.push_back(src);
    exp_err.push_back(err);
  endtask

  task automatic check_response();
    if (exp_src.size() == 0) begin
      errors++;
      $display("Response with source %h arrived with no request outstanding", in_d_source);
    end else begin
      check_value("in_d_source_o", 32'(in_d_source), 32'(exp_src[0]));
      check_value("in_d_opcode_o", 32'(in_d_opcode), 32'(exp_op[0]));
      check_value("in_d_error_o", 32'(in_d_error), 32'(exp_err[0]));
      if (exp_check_data[0]) begin
        check_value("in_d_data_o", in_d_data, exp_data[0]);
      end
      void'(exp_op.pop_front());
      void'(exp_data.pop_front());
      void'(exp_check_data.pop_front());
      void'(exp_src.pop_front());
      void'(exp_err.pop_front());
    end
  endtask

  // Response side is sampled at the falling edge, where it is stable.
  always @(negedge clk) begin
    if (rst_n) begin
      if (stalled) begin
        assert ({in_d_valid, in_d_opcode, in_d_data, in_d_source, in_d_error} === held)
          else begin
            errors++;
            $display("Mismatch in_d payload while stalled: expected %h, got %h", held,
                     {in_d_valid, in_d_opcode, in_d_data, in_d_source, in_d_error});
          end
      end
      stalled = in_d_valid && !in_d_ready;
      held    = {in_d_valid, in_d_opcode, in_d_data, in_d_source, in_d_error};
      if (in_d_valid && in_d_ready) begin
        check_response();
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (ready_random) begin
      in_d_ready = ({$random(ready_seed)} % 3) != 0;
    end else begin
      in_d_ready = 1'b1;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [AddrWidth-1:0] pick_addr(input logic in_window);
    if (in_window) begin
      return StartAddr + 32'(({$random(seed)} % Depth) * 4);
    end
    return 32'h2000_0000 + 32'(({$random(seed)} % 64) * 4);
  endfunction

  // Drives one request and records its expected response on acceptance.
  task automatic send_req(input a_op_e op, input logic [AddrWidth-1:0] addr,
                          input logic [3:0] mask, input logic [DataWidth-1:0] data);
    int waited;
    int idx;
    in_a_valid   = 1'b1;
    in_a_opcode  = op;
    in_a_address = addr;
    in_a_mask    = mask;
    in_a_data    = data;
    in_a_source  = next_src;
    waited       = 0;
    @(negedge clk);
    while (!in_a_ready && waited < Timeout) begin
      waited++;
      @(negedge clk);
    end
    if (!in_a_ready) begin
      fail_timeout("Request was not accepted before the timeout");
    end else begin
      if (addr >= StartAddr && addr < StartAddr + 32'(Depth * 4)) begin
        idx = int'((addr - StartAddr) >> 2);
        if (op == Get) begin
          expect_response(AccessAckData, ref_mem[idx], 1'b1, next_src, 1'b0);
        end else begin
          for (int b = 0; b < 4; b++) begin
            if (op == PutFullData || mask[b]) begin
              ref_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
          end
          expect_response(AccessAck, '0, 1'b0, next_src, 1'b0);
        end
      end else begin
        expect_response(AccessAckData, addr ^ 32'h5a5a5a5a, 1'b1, next_src, addr[2]);
      end
      next_src++;
      step();
      in_a_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_src.size() != 0 && waited < Timeout) begin
      waited++;
      step();
    end
    if (exp_src.size() != 0) begin
      fail_timeout("Responses were still outstanding after the timeout");
    end
  endtask

  initial begin
    a_op_e                op;
    logic [AddrWidth-1:0] addr;
    logic [3:0]           mask;
    seed         = Seed;
    ready_seed   = Seed;
    next_src     = '0;
    rst_n        = 1'b0;
    in_a_valid   = 1'b0;
    in_a_opcode  = Get;
    in_a_address = '0;
    in_a_mask    = '0;
    in_a_data    = '0;
    in_a_source  = '0;
    in_d_ready   = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (!in_d_valid && !out_a_valid)
      else begin
        errors++;
        $display("Mismatch in_d_valid_o/out_a_valid_o after reset: expected 0, got %h",
                 {in_d_valid, out_a_valid});
      end
    step();

    // Full writes across the window, then read everything back.
    for (int i = 0; i < Depth; i++) begin
      send_req(PutFullData, StartAddr + 32'(i * 4), 4'hf, $random(seed));
    end
    for (int i = 0; i < Depth; i++) begin
      send_req(Get, StartAddr + 32'(i * 4), 4'hf, '0);
    end
    wait_drain();

    // Partial writes touch only the masked bytes.
    repeat (16) begin
      mask = 4'($random(seed));
      send_req(PutPartialData, pick_addr(1'b1), mask, $random(seed));
    end
    for (int i = 0; i < Depth; i++) begin
      send_req(Get, StartAddr + 32'(i * 4), 4'hf, '0);
    end
    wait_drain();

    // Outbound traffic also covers the words just outside the window.
    send_req(Get, StartAddr - 32'd4, 4'hf, '0);
    send_req(Get, StartAddr + 32'(Depth * 4), 4'hf, '0);
    repeat (12) begin
      op = a_op_e'(2'({$random(seed)} % 3));
      send_req(op, pick_addr(1'b0), 4'($random(seed)), $random(seed));
    end
    wait_drain();

    // Mixed traffic with response back-pressure.
    ready_random = 1'b1;
    repeat (80) begin
      op   = a_op_e'(2'({$random(seed)} % 3));
      addr = pick_addr(1'($random(seed)));
      mask = (op == PutFullData) ? 4'hf : 4'($random(seed));
      send_req(op, addr, mask, $random(seed));
      repeat ({$random(seed)} % 3) step();
    end
    wait_drain();
    ready_random = 1'b0;
    repeat (10) step();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== sim_sram_sub.f ====
source/sim_sram_pkg.sv
source/sram_1p.sv
source/sram_adapter.sv
source/bus_steer.sv
source/resp_merge.sv
source/sim_sram.sv
bench/tb_downstream_model.sv
bench/tb_sim_sram.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_sim_sram
RTL_TOP    := sim_sram
FILELIST   := sim_sram_sub.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
PASS_TEXT  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
